// File: alu_ops_cfg.svh
// ----------------------------------------
// Packet geometry for the ALU ops stage
// Field count must be at least 2 so that
// pairwise operations have a partner slot
// Edit here, no per-build override
// ----------------------------------------
`ifndef ALU_OPS_CFG_SVH
`define ALU_OPS_CFG_SVH

// ----------------------------------------
// Packet shape
// ----------------------------------------

// Fields carried by one engine packet
`define ALU_OPS_NUM_FIELDS 4

// Bits per field value, also the constant width
`define ALU_OPS_DATA_W 32

// Per-field sequence state width is fixed in the package (2 bits)
// Full packet = NUM_FIELDS * (DATA_W + 2) bits

`endif

// File: alu_ops_pkg.sv
// ----------------------------------------
// Shared types for the ALU ops stage
// Geometry comes from alu_ops_cfg.svh
// Op codes 6 and 7 are unused and act
// like ALU_NOP in the kernel
// ----------------------------------------
`include "alu_ops_cfg.svh"

package alu_ops_pkg;

  // ----------------------------------------
  // Field sequence state
  // ----------------------------------------
  typedef enum logic [1:0] {
    SEQUENCE_INVALID = 2'd0,
    SEQUENCE_RUNNING = 2'd1,
    SEQUENCE_DONE    = 2'd2
  } field_state_e;

  // Packet as it streams through the engine
  // Index 0 is the result slot on the way out
  typedef struct packed {
    logic [`ALU_OPS_NUM_FIELDS-1:0][`ALU_OPS_DATA_W-1:0] field;
    field_state_e [`ALU_OPS_NUM_FIELDS-1:0]              field_state;
  } engine_packet_t;

  // ----------------------------------------
  // ALU operation set
  // ----------------------------------------
  typedef enum logic [2:0] {
    ALU_NOP = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2,
    ALU_MUL = 3'd3,
    ALU_ACC = 3'd4,
    ALU_DIV = 3'd5
  } alu_op_e;

  // ops_mask[i][j] set means input field j feeds operand slot i
  // alu_mask picks the pair base (or ACC source), highest bit wins
  typedef struct packed {
    alu_op_e                                             alu_operation;
    logic [`ALU_OPS_NUM_FIELDS-1:0]                      alu_mask;
    logic [`ALU_OPS_NUM_FIELDS-1:0][`ALU_OPS_NUM_FIELDS-1:0] ops_mask;
    logic [`ALU_OPS_NUM_FIELDS-1:0]                      const_mask;
    logic [`ALU_OPS_DATA_W-1:0]                          const_value;
  } alu_ops_config_t;

endpackage : alu_ops_pkg

// File: alu_ops_config_regs.sv
// ----------------------------------------
// Active operation set for the ALU kernel
// Loads on a one-cycle cfg_valid strobe
// clear follows every load by one cycle
// and is held high during reset
// ----------------------------------------
`timescale 1ns/1ps
`include "alu_ops_cfg.svh"

module alu_ops_config_regs import alu_ops_pkg::*; (
  input  logic            ap_clk,
  input  logic            areset,
  input  logic            cfg_valid,
  input  alu_ops_config_t cfg_in,
  output alu_ops_config_t config_params,
  output logic            clear
);

  // ----------------------------------------
  // Configuration register
  // ----------------------------------------

  // Reset leaves ALU_NOP with all masks empty
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      config_params <= '0;
    end else if (cfg_valid) begin
      config_params <= cfg_in;
    end
  end

  // ----------------------------------------
  // Accumulator clear pulse
  // ----------------------------------------

  // Same edge as the load, so clear and new params appear together
  // One trailing cycle of clear right after reset release
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      clear <= 1'b1;
    end else begin
      clear <= cfg_valid;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Routing rows must be one-hot or empty once a set is loaded
  // Two bits in a row would make the operand source ambiguous
  for (genvar g = 0; g < `ALU_OPS_NUM_FIELDS; g++) begin : g_row_chk
    a_ops_row_onehot0 : assert property (
      @(posedge ap_clk) disable iff (areset)
      cfg_valid |=> $onehot0(config_params.ops_mask[g])
    ) else $error("ops_mask row %0d has more than one bit set", g);
  end

endmodule : alu_ops_config_regs

// File: alu_ops_kernel.sv
// ----------------------------------------
// Three-stage ALU kernel
// Stage 1 routes operands, stage 2 runs
// the ALU, stage 3 assembles the output
// No valid tracking on the data path; the
// caller marks real outputs
// ----------------------------------------
`timescale 1ns/1ps
`include "alu_ops_cfg.svh"

module alu_ops_kernel import alu_ops_pkg::*; (
  input  logic            ap_clk,
  input  logic            areset,
  input  logic            clear,
  input  alu_ops_config_t config_params_in,
  input  logic            data_valid,
  input  engine_packet_t  data_in,
  output engine_packet_t  result_out
);

  localparam int NF = `ALU_OPS_NUM_FIELDS;
  localparam int DW = `ALU_OPS_DATA_W;

  // Stage 1 registers
  engine_packet_t                ops_next;
  engine_packet_t                org_next;
  engine_packet_t                ops_s1;
  engine_packet_t                org_s1;
  alu_op_e                       op_s1;
  logic [NF-1:0]                 alu_mask_s1;
  logic                          valid_s1;

  // Stage 2 operand selection and registers
  logic                          pair_hit;
  logic [DW-1:0]                 op_a;
  logic [DW-1:0]                 op_b;
  field_state_e                  pair_state;
  logic                          acc_hit;
  logic [DW-1:0]                 acc_val;
  field_state_e                  acc_state;
  logic [DW-1:0]                 abs_diff;
  logic [DW-1:0]                 mul_low;
  logic [DW-1:0]                 res_value;
  field_state_e                  res_state;
  engine_packet_t                org_s2;

  // ----------------------------------------
  // Stage 1: operand routing
  // ----------------------------------------

  always_comb begin
    ops_next = '0;
    org_next = '0;
    for (int i = 0; i < NF; i++) begin
      // Empty row gives a zero INVALID operand
      ops_next.field[i]       = '0;
      ops_next.field_state[i] = SEQUENCE_INVALID;
      // Empty row keeps the same-index field for the original copy
      org_next.field[i]       = data_in.field[i];
      org_next.field_state[i] = data_in.field_state[i];
      for (int j = 0; j < NF; j++) begin
        if (config_params_in.ops_mask[i][j]) begin
          ops_next.field[i]       = data_in.field[j];
          ops_next.field_state[i] = data_in.field_state[j];
          org_next.field[i]       = data_in.field[j];
          org_next.field_state[i] = data_in.field_state[j];
        end
      end
      // Constant overrides routing, original copy unaffected
      if (config_params_in.const_mask[i]) begin
        ops_next.field[i]       = config_params_in.const_value;
        ops_next.field_state[i] = SEQUENCE_RUNNING;
      end
    end
  end

  // Op and mask travel with the operands
  always_ff @(posedge ap_clk) begin
    ops_s1      <= ops_next;
    org_s1      <= org_next;
    op_s1       <= config_params_in.alu_operation;
    alu_mask_s1 <= config_params_in.alu_mask;
  end

  // Only the ACC path looks at valid
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= data_valid;
    end
  end

  // ----------------------------------------
  // Stage 2: ALU
  // ----------------------------------------

  // Highest set mask bit selects the slot, later iterations win
  always_comb begin
    pair_hit   = 1'b0;
    op_a       = '0;
    op_b       = '0;
    pair_state = SEQUENCE_INVALID;
    acc_hit    = 1'b0;
    acc_val    = '0;
    acc_state  = SEQUENCE_INVALID;
    // Pairs need a partner, so the top slot is no pair base
    for (int i = 0; i < NF - 1; i++) begin
      if (alu_mask_s1[i]) begin
        pair_hit   = 1'b1;
        op_a       = ops_s1.field[i];
        op_b       = ops_s1.field[i+1];
        pair_state = ops_s1.field_state[i];
      end
    end
    for (int i = 0; i < NF; i++) begin
      if (alu_mask_s1[i]) begin
        acc_hit   = 1'b1;
        acc_val   = ops_s1.field[i];
        acc_state = ops_s1.field_state[i];
      end
    end
  end

  assign abs_diff = (op_a > op_b) ? (op_a - op_b) : (op_b - op_a);
  // Low half of the product, wraps like the adder
  assign mul_low  = op_a * op_b;

  // No mask hit leaves the previous result in place
  always_ff @(posedge ap_clk) begin
    if (clear) begin
      res_value <= '0;
      res_state <= SEQUENCE_INVALID;
    end else begin
      case (op_s1)
        ALU_ADD: begin
          if (pair_hit) begin
            res_value <= op_a + op_b;
            res_state <= pair_state;
          end
        end
        ALU_SUB: begin
          if (pair_hit) begin
            res_value <= abs_diff;
            res_state <= pair_state;
          end
        end
        ALU_MUL: begin
          if (pair_hit) begin
            res_value <= mul_low;
            res_state <= pair_state;
          end
        end
        ALU_ACC: begin
          // Running sum only moves on real packets
          if (valid_s1 && acc_hit) begin
            res_value <= res_value + acc_val;
            res_state <= acc_state;
          end
        end
        default: begin
          // NOP, DIV and unused codes pass operand slot 0
          res_value <= ops_s1.field[0];
          res_state <= ops_s1.field_state[0];
        end
      endcase
    end
  end

  // Original copy delayed to line up with the ALU result
  always_ff @(posedge ap_clk) begin
    org_s2 <= org_s1;
  end

  // ----------------------------------------
  // Stage 3: output packet
  // ----------------------------------------

  always_ff @(posedge ap_clk) begin
    result_out                <= org_s2;
    result_out.field[0]       <= res_value;
    result_out.field_state[0] <= res_state;
  end

  // Unknown valid would corrupt the accumulator silently
  a_valid_known : assert property (
    @(posedge ap_clk) disable iff (areset)
    !$isunknown(data_valid)
  ) else $error("data_valid is unknown");

endmodule : alu_ops_kernel

// File: alu_ops_engine.sv
// ----------------------------------------
// ALU ops stage top level
// in_valid to out_valid is 3 cycles, one
// packet per cycle, no back-pressure
// Reconfigure only when the pipe is empty
// ----------------------------------------
`timescale 1ns/1ps

module alu_ops_engine import alu_ops_pkg::*; (
  input  logic            ap_clk,
  input  logic            areset,
  input  logic            cfg_valid,
  input  alu_ops_config_t cfg_in,
  input  logic            in_valid,
  input  engine_packet_t  in_packet,
  output logic            out_valid,
  output engine_packet_t  out_packet
);

  // Matches the kernel depth
  localparam int LATENCY = 3;

  alu_ops_config_t    config_params;
  logic               clear;
  logic [LATENCY-1:0] valid_pipe;

  // ----------------------------------------
  // Configuration
  // ----------------------------------------

  alu_ops_config_regs alu_ops_config_regs_i (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .cfg_valid     (cfg_valid),
    .cfg_in        (cfg_in),
    .config_params (config_params),
    .clear         (clear)
  );

  // ----------------------------------------
  // Data path
  // ----------------------------------------

  alu_ops_kernel alu_ops_kernel_i (
    .ap_clk           (ap_clk),
    .areset           (areset),
    .clear            (clear),
    .config_params_in (config_params),
    .data_valid       (in_valid),
    .data_in          (in_packet),
    .result_out       (out_packet)
  );

  // Valid delay line, bit 0 is one cycle old
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[LATENCY-2:0], in_valid};
    end
  end

  assign out_valid = valid_pipe[LATENCY-1];

  // ----------------------------------------
  // Configuration timing checks
  // ----------------------------------------

  // Packets in flight would see a mix of old and new settings
  a_cfg_pipe_empty : assert property (
    @(posedge ap_clk) disable iff (areset)
    cfg_valid |-> (valid_pipe == '0)
  ) else $error("cfg_valid while packets are in flight");

  // Packet in the load cycle would route with the stale set
  a_cfg_not_with_data : assert property (
    @(posedge ap_clk) disable iff (areset)
    !(cfg_valid && in_valid)
  ) else $error("cfg_valid and in_valid in the same cycle");

endmodule : alu_ops_engine

// File: tb_alu_ops.sv
// ----------------------------------------
// Self-checking testbench, ALU ops stage
// Field values come from a 32-bit xorshift,
// so ALU_OPS_DATA_W is taken as 32
// Each entry reconfigures with the pipe empty
// ----------------------------------------
`timescale 1ns/1ps
`include "alu_ops_cfg.svh"

module tb_alu_ops import alu_ops_pkg::*; ();

  localparam int  NF           = `ALU_OPS_NUM_FIELDS;
  localparam int  DW           = `ALU_OPS_DATA_W;
  localparam int  CLK_PERIOD   = 40;
  localparam int  RESET_CYCLES = 16;
  // Drive edge to the negedge where out_valid is sampled
  localparam time OUT_DELAY    = time'(3 * CLK_PERIOD + CLK_PERIOD / 2);

  // One table row, a configuration and its burst
  typedef struct {
    alu_ops_config_t cfg;
    int              count;
    logic [DW-1:0]   value_mask;
  } entry_t;

  logic            ap_clk;
  logic            areset;
  logic            cfg_valid;
  alu_ops_config_t cfg_in;
  logic            in_valid;
  engine_packet_t  in_packet;
  logic            out_valid;
  engine_packet_t  out_packet;

  entry_t          tbl[$];
  engine_packet_t  exp_q[$];
  time             time_q[$];
  logic [31:0]     rng_state;
  logic [DW-1:0]   acc_sum;
  int              cycle_count;
  int              cycle_limit;
  engine_packet_t  mon_exp;
  time             mon_time;

  alu_ops_engine alu_ops_engine_i (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .cfg_valid  (cfg_valid),
    .cfg_in     (cfg_in),
    .in_valid   (in_valid),
    .in_packet  (in_packet),
    .out_valid  (out_valid),
    .out_packet (out_packet)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // ops_mask row i sits in bits [4i+3:4i]
  function automatic alu_ops_config_t make_cfg(input logic [2:0] op_code,
      input logic [NF-1:0] alu_mask, input logic [NF*NF-1:0] ops_mask,
      input logic [NF-1:0] const_mask, input logic [DW-1:0] const_value);
    alu_ops_config_t c;
    c.alu_operation = alu_op_e'(op_code);
    c.alu_mask      = alu_mask;
    c.ops_mask      = ops_mask;
    c.const_mask    = const_mask;
    c.const_value   = const_value;
    return c;
  endfunction

  task automatic add_entry(input alu_ops_config_t cfg, input int count,
      input logic [DW-1:0] value_mask);
    entry_t e;
    e.cfg        = cfg;
    e.count      = count;
    e.value_mask = value_mask;
    tbl.push_back(e);
  endtask

  // States drawn from the three legal codes only
  function automatic engine_packet_t random_packet(input logic [DW-1:0] value_mask);
    engine_packet_t p;
    logic [31:0]    r;
    for (int f = 0; f < NF; f++) begin
      p.field[f]       = next_rand() & value_mask;
      r                = next_rand() % 32'd3;
      p.field_state[f] = field_state_e'(r[1:0]);
    end
    return p;
  endfunction

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Fields 1 and up keep the routed originals, field 0 gets the result
  function automatic engine_packet_t model_packet(input alu_ops_config_t c,
      input engine_packet_t p);
    engine_packet_t ops;
    engine_packet_t res;
    logic [DW-1:0]  a;
    logic [DW-1:0]  b;
    field_state_e   st;
    logic [DW-1:0]  acc_in;
    field_state_e   acc_st;
    for (int i = 0; i < NF; i++) begin
      ops.field[i]       = '0;
      ops.field_state[i] = SEQUENCE_INVALID;
      res.field[i]       = p.field[i];
      res.field_state[i] = p.field_state[i];
      for (int j = 0; j < NF; j++) begin
        if (c.ops_mask[i][j]) begin
          ops.field[i]       = p.field[j];
          ops.field_state[i] = p.field_state[j];
          res.field[i]       = p.field[j];
          res.field_state[i] = p.field_state[j];
        end
      end
      if (c.const_mask[i]) begin
        ops.field[i]       = c.const_value;
        ops.field_state[i] = SEQUENCE_RUNNING;
      end
    end
    a      = '0;
    b      = '0;
    st     = SEQUENCE_INVALID;
    acc_in = '0;
    acc_st = SEQUENCE_INVALID;
    // Highest mask bit with a partner slot picks the pair
    for (int i = 0; i < NF - 1; i++) begin
      if (c.alu_mask[i]) begin
        a  = ops.field[i];
        b  = ops.field[i+1];
        st = ops.field_state[i];
      end
    end
    for (int i = 0; i < NF; i++) begin
      if (c.alu_mask[i]) begin
        acc_in = ops.field[i];
        acc_st = ops.field_state[i];
      end
    end
    case (c.alu_operation)
      ALU_ADD: res.field[0] = a + b;
      ALU_SUB: res.field[0] = (a > b) ? (a - b) : (b - a);
      ALU_MUL: res.field[0] = a * b;
      ALU_ACC: begin
        acc_sum      = acc_sum + acc_in;
        res.field[0] = acc_sum;
      end
      default: res.field[0] = ops.field[0];
    endcase
    if (c.alu_operation == ALU_ACC) begin
      res.field_state[0] = acc_st;
    end else if (c.alu_operation inside {ALU_ADD, ALU_SUB, ALU_MUL}) begin
      res.field_state[0] = st;
    end else begin
      res.field_state[0] = ops.field_state[0];
    end
    return res;
  endfunction

  // ----------------------------------------
  // Checking
  // ----------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
      input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run($sformatf("Check of %s failed at %0t", name, $time));
    end
  endtask

  task automatic compare_packet(input engine_packet_t got, input engine_packet_t exp);
    for (int f = 0; f < NF; f++) begin
      check_value($sformatf("out_packet.field[%0d]", f),
                  64'(got.field[f]), 64'(exp.field[f]));
      check_value($sformatf("out_packet.field_state[%0d]", f),
                  64'(got.field_state[f]), 64'(exp.field_state[f]));
    end
  endtask

  // Outputs sampled mid-cycle, arrival time checks the 3-cycle latency
  always @(negedge ap_clk) begin
    if (!areset && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("out_valid was raised with no packet outstanding");
      end else begin
        mon_exp  = exp_q.pop_front();
        mon_time = time_q.pop_front();
        check_value("out_valid arrival time", 64'($time), 64'(mon_time));
        compare_packet(out_packet, mon_exp);
      end
    end else if (!areset && out_valid !== 1'b0) begin
      abort_run("out_valid is unknown after reset");
    end
  end

  // Watchdog
  always @(posedge ap_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      abort_run("Timeout, the run went past its cycle limit");
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic build_table();
    // NOP routing, identity then permutation
    add_entry(make_cfg(ALU_NOP, 4'b0000, 16'h8421, 4'b0000, 32'h0), 4, 32'hffff_ffff);
    add_entry(make_cfg(ALU_NOP, 4'b0000, 16'h2814, 4'b0000, 32'h0), 5, 32'hffff_ffff);
    // Constants in slots 0 and 2, row 2 empty
    add_entry(make_cfg(ALU_NOP, 4'b0000, 16'h1082, 4'b0101, 32'hcafe_0001), 4,
              32'hffff_ffff);
    // Row 0 empty, field 0 becomes zero INVALID
    add_entry(make_cfg(ALU_NOP, 4'b0000, 16'h8420, 4'b0000, 32'h0), 3, 32'hffff_ffff);
    add_entry(make_cfg(ALU_ADD, 4'b0001, 16'h8421, 4'b0000, 32'h0), 6, 32'hffff_ffff);
    // Large constant partner forces wrap
    add_entry(make_cfg(ALU_ADD, 4'b0001, 16'h8421, 4'b0010, 32'hffff_fff0), 4,
              32'hffff_ffff);
    // Bits 0..2 set, slot 2 wins
    add_entry(make_cfg(ALU_ADD, 4'b0111, 16'h1248, 4'b0000, 32'h0), 4, 32'hffff_ffff);
    add_entry(make_cfg(ALU_SUB, 4'b0001, 16'h8421, 4'b0000, 32'h0), 6, 32'hffff_ffff);
    // Mid-range constant so both operand orders occur
    add_entry(make_cfg(ALU_SUB, 4'b0001, 16'h8421, 4'b0010, 32'h0000_8000), 6,
              32'h0000_ffff);
    add_entry(make_cfg(ALU_MUL, 4'b0010, 16'h8421, 4'b0000, 32'h0), 5, 32'h0000_ffff);
    add_entry(make_cfg(ALU_MUL, 4'b0110, 16'h4821, 4'b0000, 32'h0), 4, 32'h0000_ffff);
    // Two ACC runs, the second load restarts the sum
    add_entry(make_cfg(ALU_ACC, 4'b0100, 16'h8421, 4'b0000, 32'h0), 8, 32'h0fff_ffff);
    add_entry(make_cfg(ALU_ACC, 4'b1001, 16'h8421, 4'b0000, 32'h0), 6, 32'hffff_ffff);
    add_entry(make_cfg(ALU_DIV, 4'b0011, 16'h2814, 4'b0000, 32'h0), 3, 32'hffff_ffff);
    // Unused code 6
    add_entry(make_cfg(3'd6, 4'b0001, 16'h8421, 4'b0001, 32'h1234_5678), 3,
              32'hffff_ffff);
  endtask

  // Load, back-to-back burst, then drain
  task automatic apply_entry(input entry_t e);
    engine_packet_t pkt;
    @(posedge ap_clk);
    cfg_valid <= 1'b1;
    cfg_in    <= e.cfg;
    acc_sum = '0;
    for (int k = 0; k < e.count; k++) begin
      @(posedge ap_clk);
      cfg_valid <= 1'b0;
      pkt = random_packet(e.value_mask);
      in_valid  <= 1'b1;
      in_packet <= pkt;
      exp_q.push_back(model_packet(e.cfg, pkt));
      time_q.push_back($time + OUT_DELAY);
    end
    @(posedge ap_clk);
    cfg_valid <= 1'b0;
    in_valid  <= 1'b0;
    // Valid delay line must be empty before the next load
    repeat (4) @(posedge ap_clk);
  endtask

  initial begin
    areset      = 1'b1;
    cfg_valid   = 1'b0;
    cfg_in      = '0;
    in_valid    = 1'b0;
    in_packet   = '0;
    rng_state   = 32'h3cf5_4cb5;
    acc_sum     = '0;
    cycle_count = 0;
    build_table();
    cycle_limit = RESET_CYCLES;
    for (int n = 0; n < tbl.size(); n++) begin
      cycle_limit = cycle_limit + tbl[n].count + 8;
    end
    repeat (RESET_CYCLES) @(posedge ap_clk);
    areset <= 1'b0;
    // Idle stretch, any out_valid here is caught by the monitor
    repeat (4) @(posedge ap_clk);
    for (int n = 0; n < tbl.size(); n++) begin
      apply_entry(tbl[n]);
    end
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected packets never came out", exp_q.size()));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule : tb_alu_ops

// File: verilog.f
+incdir+.
alu_ops_pkg.sv
alu_ops_config_regs.sv
alu_ops_kernel.sv
alu_ops_engine.sv
tb_alu_ops.sv

// File: Makefile
# Verilator build and run for the ALU ops stage
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_alu_ops
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= >>> FAIL
PASS_MSG  ?= >>> PASS

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and scan $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG PASS_MSG"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
